/* src/lc3b_mem_pkg.sv */
`default_nettype none

package lc3b_mem_pkg;

	// Basic LC-3b quantities
	typedef logic [15:0] lc3b_word;
	typedef logic [15:0] lc3b_addr;

	// A cache line holds 16 words and moves as one unit at every level
	typedef logic [255:0] lc3b_block;

	// The low address bits select a byte inside a line
	localparam int OFFSET_BITS = 5;
	localparam int LINE_BYTES = 32;

	// L2 controller sequence
	typedef enum logic [2:0] {
		L2_IDLE,
		L2_LOOKUP,
		L2_WRITEBACK,
		L2_FILL,
		L2_RESPOND
	} l2_state_t;

endpackage : lc3b_mem_pkg

`default_nettype wire

/* src/line_req_if.sv */
`default_nettype none

interface line_req_if;

	// The requester holds its request steady until it sees resp
	logic read;
	logic write;
	lc3b_mem_pkg::lc3b_addr address;
	lc3b_mem_pkg::lc3b_block wdata;

	// The responder answers with a one-cycle resp that qualifies rdata on a read
	lc3b_mem_pkg::lc3b_block rdata;
	logic resp;

	modport requester (
		output read, write, address, wdata,
		input rdata, resp
	);

	modport responder (
		input read, write, address, wdata,
		output rdata, resp
	);

endinterface : line_req_if

`default_nettype wire

/* src/line_arbiter.sv */
`default_nettype none

module line_arbiter (
	input logic clk,
	input logic rst_n,
	line_req_if.responder i_side,
	line_req_if.responder d_side,
	line_req_if.requester l2
);

	// High when the D side holds the grant
	logic owner_d;
	logic busy;
	logic i_req;
	logic d_req;

	assign i_req = i_side.read | i_side.write;
	assign d_req = d_side.read | d_side.write;

	// A grant is taken in an idle cycle and kept until the L2 answers
	// The D side wins a tie
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner_d <= 1'b0;
		end else if (!busy) begin
			if (d_req) begin
				busy <= 1'b1;
				owner_d <= 1'b1;
			end else if (i_req) begin
				busy <= 1'b1;
				owner_d <= 1'b0;
			end
		end else if (l2.resp) begin
			busy <= 1'b0;
		end
	end

	// The owner's request reaches the L2 only while the grant is held
	always_comb begin
		if (owner_d) begin
			l2.read = busy & d_side.read;
			l2.write = busy & d_side.write;
			l2.address = d_side.address;
			l2.wdata = d_side.wdata;
		end else begin
			l2.read = busy & i_side.read;
			l2.write = busy & i_side.write;
			l2.address = i_side.address;
			l2.wdata = i_side.wdata;
		end
	end

	// Line data is shared and resp is steered to the owner alone
	assign i_side.rdata = l2.rdata;
	assign d_side.rdata = l2.rdata;
	assign i_side.resp = busy & ~owner_d & l2.resp;
	assign d_side.resp = busy & owner_d & l2.resp;

endmodule : line_arbiter

`default_nettype wire

/* src/l2_line_cache.sv */
`default_nettype none

module l2_line_cache #(
	parameter int L2_LINES = 16
) (
	input logic clk,
	input logic rst_n,
	line_req_if.responder up,
	line_req_if.requester down
);

	localparam int ADDR_BITS = $bits(lc3b_mem_pkg::lc3b_addr);
	localparam int INDEX_BITS = $clog2(L2_LINES);
	localparam int TAG_BITS = ADDR_BITS - lc3b_mem_pkg::OFFSET_BITS - INDEX_BITS;

	lc3b_mem_pkg::l2_state_t state;
	lc3b_mem_pkg::l2_state_t state_next;

	// Direct-mapped line store
	logic [TAG_BITS-1:0] tag_mem [L2_LINES];
	lc3b_mem_pkg::lc3b_block data_mem [L2_LINES];
	logic [L2_LINES-1:0] valid;
	logic [L2_LINES-1:0] dirty;

	// Copy of the request taken on the way out of idle
	logic req_write;
	lc3b_mem_pkg::lc3b_addr req_addr;
	lc3b_mem_pkg::lc3b_block req_wdata;

	logic [INDEX_BITS-1:0] req_idx;
	logic [TAG_BITS-1:0] req_tag;
	logic hit;
	logic victim_dirty;
	logic wb_done;
	logic fill_done;
	logic wr_install;

	assign req_idx = req_addr[lc3b_mem_pkg::OFFSET_BITS +: INDEX_BITS];
	assign req_tag = req_addr[ADDR_BITS-1 -: TAG_BITS];
	assign hit = valid[req_idx] && (tag_mem[req_idx] == req_tag);
	assign victim_dirty = valid[req_idx] && dirty[req_idx] && !hit;
	assign wb_done = (state == lc3b_mem_pkg::L2_WRITEBACK) && down.resp;
	assign fill_done = (state == lc3b_mem_pkg::L2_FILL) && down.resp;

	// A write replaces the whole line, so a miss allocates without a fill
	// once any dirty victim has gone out
	assign wr_install = req_write &&
		(((state == lc3b_mem_pkg::L2_LOOKUP) && !victim_dirty) || wb_done);

	always_comb begin
		state_next = state;
		case (state)
			lc3b_mem_pkg::L2_IDLE: begin
				if (up.read || up.write) begin
					state_next = lc3b_mem_pkg::L2_LOOKUP;
				end
			end
			lc3b_mem_pkg::L2_LOOKUP: begin
				if (victim_dirty) begin
					state_next = lc3b_mem_pkg::L2_WRITEBACK;
				end else if (hit || req_write) begin
					state_next = lc3b_mem_pkg::L2_RESPOND;
				end else begin
					state_next = lc3b_mem_pkg::L2_FILL;
				end
			end
			lc3b_mem_pkg::L2_WRITEBACK: begin
				if (down.resp) begin
					state_next = req_write ? lc3b_mem_pkg::L2_RESPOND : lc3b_mem_pkg::L2_FILL;
				end
			end
			lc3b_mem_pkg::L2_FILL: begin
				if (down.resp) begin
					state_next = lc3b_mem_pkg::L2_RESPOND;
				end
			end
			default: state_next = lc3b_mem_pkg::L2_IDLE;
		endcase
	end

	// Later assignments win, so an installed write leaves the line dirty
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= lc3b_mem_pkg::L2_IDLE;
			valid <= '0;
			dirty <= '0;
		end else begin
			state <= state_next;
			if (wb_done) begin
				dirty[req_idx] <= 1'b0;
			end
			if (fill_done) begin
				valid[req_idx] <= 1'b1;
				dirty[req_idx] <= 1'b0;
			end
			if (wr_install) begin
				valid[req_idx] <= 1'b1;
				dirty[req_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == lc3b_mem_pkg::L2_IDLE) begin
			req_write <= up.write;
			req_addr <= up.address;
			req_wdata <= up.wdata;
		end
		if (wr_install) begin
			data_mem[req_idx] <= req_wdata;
			tag_mem[req_idx] <= req_tag;
		end else if (fill_done) begin
			data_mem[req_idx] <= down.rdata;
			tag_mem[req_idx] <= req_tag;
		end
	end

	// Writeback uses the victim's own tag and the fill uses the request's
	assign down.read = (state == lc3b_mem_pkg::L2_FILL);
	assign down.write = (state == lc3b_mem_pkg::L2_WRITEBACK);
	assign down.address = (state == lc3b_mem_pkg::L2_WRITEBACK) ?
		{tag_mem[req_idx], req_idx, {lc3b_mem_pkg::OFFSET_BITS{1'b0}}} :
		{req_tag, req_idx, {lc3b_mem_pkg::OFFSET_BITS{1'b0}}};
	assign down.wdata = data_mem[req_idx];

	assign up.rdata = data_mem[req_idx];
	assign up.resp = (state == lc3b_mem_pkg::L2_RESPOND);

endmodule : l2_line_cache

`default_nettype wire

/* src/next_line_prefetch.sv */
`default_nettype none

module next_line_prefetch (
	input logic clk,
	input logic rst_n,
	line_req_if.responder up,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_mem_pkg::lc3b_addr pmem_address,
	output lc3b_mem_pkg::lc3b_block pmem_wdata,
	input lc3b_mem_pkg::lc3b_block pmem_rdata,
	input logic pmem_resp
);

	// One buffered line
	lc3b_mem_pkg::lc3b_addr buf_addr;
	lc3b_mem_pkg::lc3b_block buf_data;
	logic buf_valid;

	// Background fetch of the line after the last forwarded read
	logic pf_busy;
	lc3b_mem_pkg::lc3b_addr pf_addr;

	logic hit_resp;
	lc3b_mem_pkg::lc3b_addr up_line;
	logic buf_hit;
	logic demand_ok;
	logic fwd_read;
	logic fwd_write;

	assign up_line = {up.address[15:lc3b_mem_pkg::OFFSET_BITS],
		{lc3b_mem_pkg::OFFSET_BITS{1'b0}}};
	assign buf_hit = buf_valid && (buf_addr == up_line);

	// Demand traffic waits while the background fetch owns memory
	assign demand_ok = !pf_busy && !hit_resp;
	assign fwd_read = demand_ok && up.read && !buf_hit;
	assign fwd_write = demand_ok && up.write;

	assign pmem_read = pf_busy || fwd_read;
	assign pmem_write = fwd_write;
	assign pmem_address = pf_busy ? pf_addr : up.address;
	assign pmem_wdata = up.wdata;

	// Buffer hits answer a cycle later and forwarded requests answer with memory
	assign up.rdata = hit_resp ? buf_data : pmem_rdata;
	assign up.resp = hit_resp || ((fwd_read || fwd_write) && pmem_resp);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_valid <= 1'b0;
			pf_busy <= 1'b0;
			hit_resp <= 1'b0;
		end else begin
			hit_resp <= demand_ok && up.read && buf_hit;
			if (pf_busy) begin
				if (pmem_resp) begin
					pf_busy <= 1'b0;
					buf_valid <= 1'b1;
				end
			end else if (fwd_read && pmem_resp) begin
				pf_busy <= 1'b1;
			end else if (fwd_write && pmem_resp && buf_hit) begin
				// Memory now holds newer data than the buffer
				buf_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fwd_read && pmem_resp) begin
			pf_addr <= up_line + lc3b_mem_pkg::lc3b_addr'(lc3b_mem_pkg::LINE_BYTES);
		end
		if (pf_busy && pmem_resp) begin
			buf_addr <= pf_addr;
			buf_data <= pmem_rdata;
		end
	end

endmodule : next_line_prefetch

`default_nettype wire

/* src/mem_hier.sv */
`default_nettype none

module mem_hier #(
	parameter int L2_LINES = 16
) (
	input logic clk,
	input logic rst_n,
	input logic i_read,
	input lc3b_mem_pkg::lc3b_addr i_address,
	output lc3b_mem_pkg::lc3b_block i_rdata,
	output logic i_resp,
	input logic d_read,
	input logic d_write,
	input lc3b_mem_pkg::lc3b_addr d_address,
	input lc3b_mem_pkg::lc3b_block d_wdata,
	output lc3b_mem_pkg::lc3b_block d_rdata,
	output logic d_resp,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_mem_pkg::lc3b_addr pmem_address,
	output lc3b_mem_pkg::lc3b_block pmem_wdata,
	input lc3b_mem_pkg::lc3b_block pmem_rdata,
	input logic pmem_resp
);

	line_req_if i_if ();
	line_req_if d_if ();
	line_req_if l2_if ();
	line_req_if mem_if ();

	// The I side only ever reads
	assign i_if.read = i_read;
	assign i_if.write = 1'b0;
	assign i_if.address = i_address;
	assign i_if.wdata = '0;
	assign i_rdata = i_if.rdata;
	assign i_resp = i_if.resp;

	assign d_if.read = d_read;
	assign d_if.write = d_write;
	assign d_if.address = d_address;
	assign d_if.wdata = d_wdata;
	assign d_rdata = d_if.rdata;
	assign d_resp = d_if.resp;

	line_arbiter u_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.i_side(i_if),
		.d_side(d_if),
		.l2(l2_if)
	);

	l2_line_cache #(
		.L2_LINES(L2_LINES)
	) u_l2 (
		.clk(clk),
		.rst_n(rst_n),
		.up(l2_if),
		.down(mem_if)
	);

	next_line_prefetch u_prefetch (
		.clk(clk),
		.rst_n(rst_n),
		.up(mem_if),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

endmodule : mem_hier

`default_nettype wire

/* verification/mem_hier_tb.sv */
`default_nettype none

module mem_hier_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] SEED = 32'h7bce_7ecb;

	logic clk;
	logic rst_n;
	logic i_read;
	lc3b_mem_pkg::lc3b_addr i_address;
	lc3b_mem_pkg::lc3b_block i_rdata;
	logic i_resp;
	logic d_read;
	logic d_write;
	lc3b_mem_pkg::lc3b_addr d_address;
	lc3b_mem_pkg::lc3b_block d_wdata;
	lc3b_mem_pkg::lc3b_block d_rdata;
	logic d_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_mem_pkg::lc3b_addr pmem_address;
	lc3b_mem_pkg::lc3b_block pmem_wdata;
	lc3b_mem_pkg::lc3b_block pmem_rdata;
	logic pmem_resp;

	// Expected line contents and the memory model's own copy are keyed by line address
	lc3b_mem_pkg::lc3b_block shadow [int];
	lc3b_mem_pkg::lc3b_block mem [int];
	int read_count [int];
	logic [31:0] rng_state;
	int value_errors;
	int other_errors;
	int writebacks;
	int i_issued;
	int d_issued;
	int i_seen;
	int d_seen;
	int n_cases;
	bit cases_loaded;
	byte q_op [$];
	byte q_port [$];
	logic [15:0] q_addr [$];
	logic [31:0] q_seed [$];

	mem_hier uut (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic lc3b_mem_pkg::lc3b_block make_line(input logic [31:0] seed);
		logic [31:0] s;
		lc3b_mem_pkg::lc3b_block b;
		s = seed;
		for (int w = 0; w < 16; w++) begin
			s = lcg_next(s);
			b[w*16 +: 16] = s[31:16];
		end
		return b;
	endfunction

	function automatic int line_key(input lc3b_mem_pkg::lc3b_addr a);
		return int'({a[15:5], 5'b0});
	endfunction

	function automatic lc3b_mem_pkg::lc3b_block expected_line(input lc3b_mem_pkg::lc3b_addr a);
		int key;
		key = line_key(a);
		return shadow.exists(key) ? shadow[key] : make_line(SEED ^ key);
	endfunction

	function automatic int reads_of(input lc3b_mem_pkg::lc3b_addr a);
		return read_count.exists(line_key(a)) ? read_count[line_key(a)] : 0;
	endfunction

	task automatic check_value(input string name, input logic [255:0] expected,
			input logic [255:0] actual);
		if (actual !== expected) begin
			$display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	// Issues one request on a port, holds it until resp and checks it against the shadow
	task automatic access(input bit on_d, input bit wr, input lc3b_mem_pkg::lc3b_addr addr,
			input lc3b_mem_pkg::lc3b_block wdata, output time resp_at);
		@(posedge clk);
		#1;
		if (on_d || wr) begin
			d_read = !wr;
			d_write = wr;
			d_address = addr;
			d_wdata = wdata;
			d_issued++;
		end else begin
			i_read = 1'b1;
			i_address = addr;
			i_issued++;
		end
		do @(negedge clk); while (!((on_d || wr) ? d_resp : i_resp));
		resp_at = $time;
		if (wr) begin
			shadow[line_key(addr)] = wdata;
		end else if (on_d) begin
			check_value("d_rdata", expected_line(addr), d_rdata);
		end else begin
			check_value("i_rdata", expected_line(addr), i_rdata);
		end
		@(posedge clk);
		#1;
		if (on_d || wr) begin
			d_read = 1'b0;
			d_write = 1'b0;
		end else begin
			i_read = 1'b0;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Physical memory answers each request after 3 to 6 cycles
	initial begin : memory_model
		int lat;
		int key;
		logic is_write;
		lc3b_mem_pkg::lc3b_block wdata;
		pmem_resp = 1'b0;
		pmem_rdata = '0;
		rng_state = SEED;
		forever begin
			@(negedge clk);
			if (rst_n && (pmem_read || pmem_write)) begin
				if (pmem_read && pmem_write) begin
					$display("Memory saw a read and a write at once at %0d ns", $time);
					other_errors++;
				end
				key = line_key(pmem_address);
				is_write = pmem_write;
				wdata = pmem_wdata;
				if (is_write) begin
					// An evicted line must carry its latest content
					check_value("pmem_wdata", expected_line(pmem_address), wdata);
					writebacks++;
				end else begin
					read_count[key] = reads_of(pmem_address) + 1;
				end
				rng_state = lcg_next(rng_state);
				lat = 3 + int'(rng_state[31:30]);
				repeat (lat - 1) @(posedge clk);
				#1;
				if (is_write) begin
					mem[key] = wdata;
				end else begin
					pmem_rdata = mem.exists(key) ? mem[key] : make_line(SEED ^ key);
				end
				pmem_resp = 1'b1;
				@(posedge clk);
				#1;
				pmem_resp = 1'b0;
			end
		end
	end

	initial begin : resp_monitor
		forever begin
			@(negedge clk);
			if (!rst_n) begin
				if ((i_resp !== 1'b0) || (d_resp !== 1'b0) ||
						(pmem_read !== 1'b0) || (pmem_write !== 1'b0)) begin
					$display("An output was active during reset at %0d ns", $time);
					other_errors++;
				end
			end else begin
				if (i_resp) i_seen++;
				if (d_resp) d_seen++;
			end
		end
	end

	initial begin : watchdog
		wait (cases_loaded);
		repeat (n_cases * 200 + 20) @(posedge clk);
		$display("Watchdog expired before all cases finished");
		$display("Checks failed: %0d, other errors: %0d", value_errors, other_errors + 1);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : case_player
		int fd;
		string text;
		logic [15:0] a;
		logic [31:0] s;
		time d_at;
		time i_at;
		int prefetched;
		rst_n = 1'b0;
		i_read = 1'b0;
		i_address = '0;
		d_read = 1'b0;
		d_write = 1'b0;
		d_address = '0;
		d_wdata = '0;
		fd = $fopen("verification/mem_hier_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the cases file");
			other_errors++;
		end else begin
			while ($fgets(text, fd) > 0) begin
				if (text.len() > 8 && text[0] != "#") begin
					void'($sscanf(text.substr(4, text.len() - 1), "%h %h", a, s));
					q_op.push_back(text[0]);
					q_port.push_back(text[2]);
					q_addr.push_back(a);
					q_seed.push_back(s);
				end
			end
			$fclose(fd);
		end
		n_cases = q_op.size();
		cases_loaded = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (q_op[k]) begin
			case (q_op[k])
				"R": access(q_port[k] == "D", 1'b0, q_addr[k], '0, d_at);
				"W": access(1'b1, 1'b1, q_addr[k], make_line(q_seed[k]), d_at);
				"F": begin
					// The cold read of the previous line has already started the prefetch
					prefetched = reads_of(q_addr[k]);
					check_value("prefetch pmem_read count", 256'(1), 256'(prefetched));
					access(q_port[k] == "D", 1'b0, q_addr[k], '0, d_at);
					// Only the background prefetch may have read this line
					check_value("pmem_read count", 256'(1), 256'(reads_of(q_addr[k])));
				end
				"P": begin
					fork
						access(1'b1, 1'b0, q_addr[k], '0, d_at);
						access(1'b0, 1'b0, q_seed[k][15:0], '0, i_at);
					join
					if (d_at > i_at) begin
						$display("D side answered after I side in a tie at %0d ns", $time);
						other_errors++;
					end
				end
				default: begin
					$display("Unknown operation in case %0d", k);
					other_errors++;
				end
			endcase
		end
		repeat (4) @(posedge clk);
		check_value("i_resp count", 256'(i_issued), 256'(i_seen));
		check_value("d_resp count", 256'(d_issued), 256'(d_seen));
		if (writebacks == 0) begin
			$display("No line was ever written back to memory");
			other_errors++;
		end
		$display("Checks failed: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule : mem_hier_tb

`default_nettype wire

/* mem_hier.f */
src/lc3b_mem_pkg.sv
src/line_req_if.sv
src/line_arbiter.sv
src/l2_line_cache.sv
src/next_line_prefetch.sv
src/mem_hier.sv
verification/mem_hier_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mem_hier_tb
FILELIST ?= mem_hier.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_MSG ?= Simulation finished: PASS

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/mem_hier_cases.txt */
# op port address seed, fixed columns, address and seed in hex
# op R read, W write on D, F read that must not refetch, P paired read with seed as I address
R D 0000 0000
R I 0020 0000
R D 0000 0000
W D 0080 1a2b
R I 0080 0000
W D 0040 5eed
R I 0240 0000
R D 0040 0000
P D 0600 0700
P D 0080 0640
R D 0400 0000
F D 0420 0000
R D 0100 0000
W D 0120 c0de
W D 0320 beef
R D 0120 0000
R I 0320 0000
